// ==== source/nna_pkg.sv ====
package nna_pkg;

	// ========================================
	// Layer sizes
	// ========================================

	// Neurons in one layer, one done bit each in the status word
	localparam int NNA_NEURONS = 8;

	// Entries in each weight memory and each input memory
	localparam int NNA_DEPTH = 64;

	// Index width of the weight and input memories
	localparam int NNA_AW = 6;

	// The input count runs 0..NNA_DEPTH inclusive, so it needs one more bit
	localparam int NNA_CW = NNA_AW + 1;

	// Width of the neuron select that a read takes from operand a
	localparam int NNA_SELW = $clog2(NNA_NEURONS);

	// Fraction bits of the Q16.16 format
	localparam int NNA_FRAC = 16;

	// ========================================
	// Value types
	// ========================================

	// Q16.16 word for weights, inputs, bias and neuron output
	typedef logic signed [31:0] fix_t;

	// Dot-product accumulator, wide enough for a run of modest products
	typedef logic signed [47:0] acc_t;

	// Operand and result word of the host instructions
	typedef logic [63:0] value_t;

	// Saturation limits of the neuron output
	localparam fix_t FIX_MAX = {1'b0, {31{1'b1}}};
	localparam fix_t FIX_MIN = {1'b1, {31{1'b0}}};

	// ========================================
	// Instruction format
	// ========================================

	// Opcode sits in the low bits, the function code right above it
	typedef struct packed {
		logic [18:0] rsvd;
		logic [5:0]  func;
		logic [6:0]  opcode;
	} instruction_t;

	// One-operand group, reads and the trigger
	localparam logic [6:0] OP_R1 = 7'h02;
	// Two-operand group, all writes into the neurons
	localparam logic [6:0] OP_R2 = 7'h0c;

	// Function codes of the one-operand group
	localparam logic [5:0] NNA_MFACT  = 6'h00;
	localparam logic [5:0] NNA_TRIG   = 6'h01;
	localparam logic [5:0] NNA_STAT   = 6'h02;

	// Function codes of the two-operand group
	localparam logic [5:0] NNA_MTWT   = 6'h08;
	localparam logic [5:0] NNA_MTIN   = 6'h09;
	localparam logic [5:0] NNA_MTBIAS = 6'h0a;
	localparam logic [5:0] NNA_MTMC   = 6'h0b;
	localparam logic [5:0] NNA_MTFB   = 6'h0c;

endpackage

// ==== source/nna_mac_fx.sv ====
`timescale 1ns/1ps

// Two-stage fixed-point multiply-accumulate
// The first stage registers the scaled product of w and x, the second adds
// that product into the accumulator one cycle later
module nna_mac_fx
	import nna_pkg::*;
(
	input  logic clk,
	input  logic arst_n,
	input  logic clear,
	input  logic en,
	input  fix_t w,
	input  fix_t x,
	output acc_t acc
);

	// Full signed product of two Q16.16 values is Q32.32
	logic signed [63:0] prod_full;
	// Product rescaled back to 16 fraction bits
	logic signed [63:0] prod_shift;
	// Registered product and its valid flag
	acc_t prod_q;
	logic prod_vld;

	// ========================================
	// Multiply stage
	// ========================================

	// Both operands are signed, so the multiply is signed as well
	assign prod_full = w * x;

	// Arithmetic shift floors toward minus infinity
	assign prod_shift = prod_full >>> NNA_FRAC;

	// The product only loads while a weight and input pair is presented
	// The valid flag trails en by one cycle to line up with the adder
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			prod_q   <= '0;
			prod_vld <= 1'b0;
		end else if (clear) begin
			prod_q   <= '0;
			prod_vld <= 1'b0;
		end else begin
			prod_vld <= en;
			if (en) begin
				// At most 2^46 in magnitude after the shift, so 48 bits hold it
				prod_q <= prod_shift[47:0];
			end
		end
	end

	// ========================================
	// Accumulate stage
	// ========================================

	// A product joins the sum one cycle after its operands were read
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			acc <= '0;
		end else if (clear) begin
			acc <= '0;
		end else if (prod_vld) begin
			// Wraps silently in 48 bits
			acc <= acc + prod_q;
		end
	end

endmodule

// ==== source/nna_neuron_fx.sv ====
`timescale 1ns/1ps

// One neuron of the layer
// It holds its own weights and inputs, runs a serial dot product through
// the MAC, adds the bias, saturates, optionally applies ReLU and then
// raises done until the next start
module nna_neuron_fx
	import nna_pkg::*;
(
	input  logic              clk,
	input  logic              arst_n,
	input  logic              sync,
	input  logic              wr,
	input  logic              wrx,
	input  logic              wrb,
	input  logic              wrm,
	input  logic              wf,
	input  logic [NNA_AW-1:0] wa,
	input  fix_t              i,
	output fix_t              o,
	output logic              done
);

	// Sequencer states
	// RUN streams pairs into the MAC, DRAIN lets the last product land and
	// FIN is the cycle where the accumulator holds the final sum
	typedef enum logic [1:0] {
		S_IDLE,
		S_RUN,
		S_DRAIN,
		S_FIN
	} state_t;

	fix_t wmem [NNA_DEPTH];
	fix_t xmem [NNA_DEPTH];

	fix_t              bias;
	logic [NNA_CW-1:0] cnt;
	logic [NNA_CW-1:0] cnt_in;
	logic              relu;

	state_t            state;
	logic [NNA_AW-1:0] idx;
	logic              start;
	logic              mac_en;
	acc_t              acc;
	acc_t              sum;
	fix_t              sat;
	fix_t              act;

	// ========================================
	// Host writes
	// ========================================

	// Weights and inputs share the index and data bus from the layer
	always_ff @(posedge clk) begin
		if (wr) begin
			wmem[wa] <= i;
		end
		if (wrx) begin
			xmem[wa] <= i;
		end
	end

	// Counts above the memory depth read as the full depth
	assign cnt_in = i[NNA_CW-1:0];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			bias <= '0;
			cnt  <= '0;
			relu <= 1'b0;
		end else begin
			if (wrb) begin
				bias <= i;
			end
			if (wrm) begin
				cnt <= (cnt_in > NNA_CW'(NNA_DEPTH)) ? NNA_CW'(NNA_DEPTH) : cnt_in;
			end
			if (wf) begin
				// Bit 0 of the data word selects ReLU, clear means identity
				relu <= i[0];
			end
		end
	end

	// ========================================
	// Sequencer
	// ========================================

	// A trigger only counts while the neuron is idle
	assign start  = sync && (state == S_IDLE);
	assign mac_en = (state == S_RUN);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= S_IDLE;
			idx   <= '0;
		end else begin
			case (state)
				S_IDLE: begin
					if (start) begin
						idx <= '0;
						// With no inputs the bias alone goes through
						state <= (cnt == '0) ? S_DRAIN : S_RUN;
					end
				end
				S_RUN: begin
					if ({1'b0, idx} == cnt - 1'b1) begin
						state <= S_DRAIN;
					end else begin
						idx <= idx + 1'b1;
					end
				end
				S_DRAIN: state <= S_FIN;
				default: state <= S_IDLE;
			endcase
		end
	end

	// Memories are read asynchronously at the current index
	nna_mac_fx u_mac (
		.clk    (clk),
		.arst_n (arst_n),
		.clear  (start),
		.en     (mac_en),
		.w      (wmem[idx]),
		.x      (xmem[idx]),
		.acc    (acc)
	);

	// ========================================
	// Output stage
	// ========================================

	// The bias is sign-extended into the accumulator width before the add
	assign sum = acc + acc_t'(bias);

	always_comb begin
		if (sum > acc_t'(FIX_MAX)) begin
			sat = FIX_MAX;
		end else if (sum < acc_t'(FIX_MIN)) begin
			sat = FIX_MIN;
		end else begin
			sat = sum[31:0];
		end
	end

	// ReLU clamps negative results to zero
	assign act = (relu && sat[31]) ? '0 : sat;

	// Done drops at the start edge and rises with the new output
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			o    <= '0;
			done <= 1'b0;
		end else if (start) begin
			done <= 1'b0;
		end else if (state == S_FIN) begin
			o    <= act;
			done <= 1'b1;
		end
	end

endmodule

// ==== source/nna_layer_fx.sv ====
`timescale 1ns/1ps

// Layer of neurons behind the custom instruction decoder
// Writes and triggers fan out to the neurons picked by the mask in a,
// reads are selected combinationally for the top level to register
module nna_layer_fx
	import nna_pkg::*;
(
	input  logic         clk,
	input  logic         arst_n,
	input  logic         instr_valid,
	input  instruction_t ir,
	input  value_t       a,
	input  value_t       b,
	output value_t       rsel,
	output logic         rd_en
);

	// Neuron mask of writes and triggers
	logic [NNA_NEURONS-1:0] mask;

	// Per-neuron strobes
	logic [NNA_NEURONS-1:0] sync;
	logic [NNA_NEURONS-1:0] wr;
	logic [NNA_NEURONS-1:0] wrx;
	logic [NNA_NEURONS-1:0] wrb;
	logic [NNA_NEURONS-1:0] wrm;
	logic [NNA_NEURONS-1:0] wf;

	// Shared memory index and data word
	logic [NNA_AW-1:0] wa;
	fix_t              wdata;

	// Neuron results
	fix_t                   neuron_o [NNA_NEURONS];
	logic [NNA_NEURONS-1:0] done;
	fix_t                   sel_o;

	assign mask  = a[NNA_NEURONS-1:0];
	assign wa    = b[NNA_AW-1:0];
	assign wdata = b[63:32];

	// ========================================
	// Instruction decode
	// ========================================

	// Unknown opcodes and function codes fall through with every strobe low
	always_comb begin
		sync  = '0;
		wr    = '0;
		wrx   = '0;
		wrb   = '0;
		wrm   = '0;
		wf    = '0;
		rd_en = 1'b0;
		if (instr_valid) begin
			case (ir.opcode)
				OP_R1: begin
					case (ir.func)
						NNA_TRIG:            sync  = mask;
						NNA_MFACT, NNA_STAT: rd_en = 1'b1;
						default:             ;
					endcase
				end
				OP_R2: begin
					case (ir.func)
						NNA_MTWT:   wr  = mask;
						NNA_MTIN:   wrx = mask;
						NNA_MTBIAS: wrb = mask;
						NNA_MTMC:   wrm = mask;
						NNA_MTFB:   wf  = mask;
						default:    ;
					endcase
				end
				default: ;
			endcase
		end
	end

	// ========================================
	// Read select
	// ========================================

	assign sel_o = neuron_o[a[NNA_SELW-1:0]];

	// Status reads return the done vector zero-extended
	// Anything else presents the selected neuron output sign-extended
	always_comb begin
		if (ir.func == NNA_STAT) begin
			rsel = value_t'(done);
		end else begin
			rsel = {{32{sel_o[31]}}, sel_o};
		end
	end

	// ========================================
	// Neurons
	// ========================================

	for (genvar g = 0; g < NNA_NEURONS; g++) begin : g_neuron
		nna_neuron_fx u_neuron (
			.clk    (clk),
			.arst_n (arst_n),
			.sync   (sync[g]),
			.wr     (wr[g]),
			.wrx    (wrx[g]),
			.wrb    (wrb[g]),
			.wrm    (wrm[g]),
			.wf     (wf[g]),
			.wa     (wa),
			.i      (wdata),
			.o      (neuron_o[g]),
			.done   (done[g])
		);
	end

endmodule

// ==== source/nna_unit_top.sv ====
`timescale 1ns/1ps

// Top level of the accelerator
// The layer decodes the instruction, this level adds the read register so
// results appear one cycle after the instruction is sampled
module nna_unit_top
	import nna_pkg::*;
(
	input  logic         clk,
	input  logic         arst_n,
	input  logic         instr_valid,
	input  instruction_t ir,
	input  value_t       a,
	input  value_t       b,
	output value_t       rdata
);

	// Combinational read data from the layer
	value_t rsel;
	// High for MFACT and STAT only
	logic   rd_en;

	nna_layer_fx u_layer (
		.clk         (clk),
		.arst_n      (arst_n),
		.instr_valid (instr_valid),
		.ir          (ir),
		.a           (a),
		.b           (b),
		.rsel        (rsel),
		.rd_en       (rd_en)
	);

	// ========================================
	// Read data register
	// ========================================

	// Loads only on reads, so writes and triggers leave the last result
	// in place for the host
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rdata <= '0;
		end else if (rd_en) begin
			rdata <= rsel;
		end
	end

endmodule

// ==== dv/nna_tb.sv ====
`timescale 1ns/1ps

module nna_tb
	import nna_pkg::*;
();

	// Data modes of a table row
	localparam logic [1:0] DM_RAND = 2'd0;
	localparam logic [1:0] DM_KEEP = 2'd1;
	localparam logic [1:0] DM_POS  = 2'd2;
	localparam logic [1:0] DM_NEG  = 2'd3;
	localparam int NROWS = 9;

	// Saturation limits written out in the accumulator width
	localparam acc_t ACC_HI = 48'sh0000_7fff_ffff;
	localparam acc_t ACC_LO = 48'shffff_8000_0000;
	// 256.0 in Q16.16, large enough that four products overflow 32 bits
	localparam fix_t BIG = 32'sh0100_0000;

	typedef struct packed {
		logic [7:0] mask;
		logic [6:0] cnt;
		fix_t       bias;
		logic       relu;
		logic [1:0] mode;
		logic       ovr_en;
		fix_t       ovr;
	} row_t;

	logic         clk;
	logic         arst_n;
	logic         instr_valid;
	instruction_t ir;
	value_t       a;
	value_t       b;
	value_t       rdata;

	// Shadow copy of everything the host wrote into each neuron
	fix_t       tb_w [8][64];
	fix_t       tb_x [8][64];
	fix_t       tb_bias [8];
	int         tb_cnt [8];
	logic       tb_relu [8];
	fix_t       exp_out [8];
	logic [7:0] exp_done;
	logic [31:0] lcg_state;
	row_t       rows [NROWS];

	nna_unit_top DUT (
		.clk         (clk),
		.arst_n      (arst_n),
		.instr_valid (instr_valid),
		.ir          (ir),
		.a           (a),
		.b           (b),
		.rdata       (rdata)
	);

	always #5 clk = ~clk;

	// ========================================
	// Helpers
	// ========================================

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// Upper 19 bits give a value in [-4.0, 4.0)
	function automatic fix_t rand_fix();
		logic [31:0] r;
		r = lcg_next();
		return fix_t'({13'b0, r[31:13]}) - 32'sd262144;
	endfunction

	// Floored products summed in 48 bits, bias, saturation, then ReLU
	function automatic fix_t model_out(input int n);
		acc_t               sum;
		logic signed [63:0] p;
		int                 c;
		int                 k;
		fix_t               r;
		sum = '0;
		c = (tb_cnt[n] > 64) ? 64 : tb_cnt[n];
		for (k = 0; k < c; k++) begin
			p = tb_w[n][k] * tb_x[n][k];
			p = p >>> 16;
			sum = sum + p[47:0];
		end
		sum = sum + {{16{tb_bias[n][31]}}, tb_bias[n]};
		if (sum > ACC_HI) begin
			r = 32'sh7fff_ffff;
		end else if (sum < ACC_LO) begin
			r = 32'sh8000_0000;
		end else begin
			r = sum[31:0];
		end
		if (tb_relu[n] && r[31]) begin
			r = '0;
		end
		return r;
	endfunction

	task automatic check(input string name, input value_t got, input value_t exp);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
			$display("*** FAILED ***");
			$fatal(1, "Stopped at the first mismatch");
		end
	endtask

	// Called at a falling edge, returns at the next falling edge
	task automatic issue(input logic vld, input logic [6:0] op, input logic [5:0] fn,
			input value_t aa, input value_t bb);
		ir          = '0;
		ir.opcode   = op;
		ir.func     = fn;
		a           = aa;
		b           = bb;
		instr_valid = vld;
		@(posedge clk);
		@(negedge clk);
		instr_valid = 1'b0;
	endtask

	task automatic write_op(input logic [5:0] fn, input logic [7:0] m, input fix_t d,
			input int idx);
		issue(1'b1, OP_R2, fn, value_t'(m), {d, 32'(idx)});
	endtask

	// The read register loaded at the sampling edge, so rdata is stable here
	task automatic read_op(input logic [5:0] fn, input int sel, output value_t got);
		issue(1'b1, OP_R1, fn, value_t'(sel), '0);
		got = rdata;
	endtask

	// Polls the status word until every masked neuron reports done
	task automatic wait_done(input logic [7:0] m);
		value_t st;
		int     tries;
		logic   seen;
		tries = 0;
		seen  = 1'b0;
		while (!seen && tries < 200) begin
			read_op(NNA_STAT, 0, st);
			seen = ((st[7:0] & m) == m);
			tries++;
		end
		if (!seen) begin
			$display("Error at %0t: neuron done never asserted for mask %h", $time, m);
			$display("*** FAILED ***");
			$fatal(1, "Stopped on a timeout");
		end
	endtask

	task automatic trigger(input logic [7:0] m);
		issue(1'b1, OP_R1, NNA_TRIG, value_t'(m), '0);
		exp_done = exp_done & ~m;
		wait_done(m);
		exp_done = exp_done | m;
	endtask

	task automatic check_outputs(input logic [7:0] m, input logic use_ovr, input fix_t ovr);
		value_t got;
		fix_t   e;
		int     n;
		for (n = 0; n < 8; n++) begin
			if (m[n]) begin
				e = use_ovr ? ovr : model_out(n);
				read_op(NNA_MFACT, n, got);
				check($sformatf("neuron_o[%0d]", n), got, {{32{e[31]}}, e});
				exp_out[n] = e;
			end
		end
	endtask

	// ========================================
	// Stimulus table
	// ========================================

	task automatic load_table();
		// Single neuron, identity
		rows[0] = '{8'h01, 7'd12, 32'sh0001_8000, 1'b0, DM_RAND, 1'b0, 32'sh0};
		// Broadcast inputs, every neuron with its own weights, bias and count
		rows[1] = '{8'hff, 7'd20, 32'shffff_4000, 1'b0, DM_RAND, 1'b0, 32'sh0};
		// Bias of -200.0 keeps the sum negative, first with ReLU then without
		rows[2] = '{8'h04, 7'd8, 32'shff38_0000, 1'b1, DM_RAND, 1'b1, 32'sh0};
		rows[3] = '{8'h04, 7'd8, 32'shff38_0000, 1'b0, DM_KEEP, 1'b0, 32'sh0};
		// Saturation at both ends
		rows[4] = '{8'h01, 7'd4, 32'sh0, 1'b0, DM_POS, 1'b1, 32'sh7fff_ffff};
		rows[5] = '{8'h01, 7'd4, 32'sh0, 1'b0, DM_NEG, 1'b1, 32'sh8000_0000};
		// Count of 0 on neuron 5 returns its bias, 3.25 plus the 2.5 offset
		rows[6] = '{8'h20, 7'd0, 32'sh0003_4000, 1'b0, DM_KEEP, 1'b1, 32'sh0005_c000};
		// Count above the depth is clamped to 64
		rows[7] = '{8'h01, 7'd70, 32'sh0002_0000, 1'b1, DM_RAND, 1'b0, 32'sh0};
		rows[8] = '{8'h0a, 7'd30, 32'sh0000_4000, 1'b1, DM_RAND, 1'b0, 32'sh0};
	endtask

	// Neuron n takes count minus n and bias plus n times 0.5
	task automatic apply_row(input row_t r);
		int   n;
		int   k;
		int   cn;
		fix_t v;
		for (k = 0; k < r.cnt && k < 64 && r.mode != DM_KEEP; k++) begin
			v = (r.mode == DM_RAND) ? rand_fix() : (r.mode == DM_POS) ? BIG : -BIG;
			write_op(NNA_MTIN, r.mask, v, k);
			for (n = 0; n < 8; n++) begin
				if (r.mask[n]) begin
					tb_x[n][k] = v;
				end
			end
		end
		for (n = 0; n < 8; n++) begin
			if (r.mask[n]) begin
				cn = (r.cnt > n) ? r.cnt - n : 0;
				for (k = 0; k < cn && k < 64 && r.mode != DM_KEEP; k++) begin
					v = (r.mode == DM_RAND) ? rand_fix() : BIG;
					write_op(NNA_MTWT, 8'(1 << n), v, k);
					tb_w[n][k] = v;
				end
				tb_cnt[n]  = cn;
				tb_bias[n] = r.bias + fix_t'(n * 32'sh8000);
				tb_relu[n] = r.relu;
				write_op(NNA_MTMC, 8'(1 << n), fix_t'(cn), 0);
				write_op(NNA_MTBIAS, 8'(1 << n), tb_bias[n], 0);
				write_op(NNA_MTFB, 8'(1 << n), fix_t'(r.relu), 0);
			end
		end
	endtask

	// ========================================
	// Main sequence
	// ========================================

	initial begin
		value_t got;
		int     n;
		int     row;
		clk         = 1'b0;
		arst_n      = 1'b0;
		instr_valid = 1'b0;
		ir          = '0;
		a           = '0;
		b           = '0;
		lcg_state   = 32'h93ff69da;
		exp_done    = '0;
		for (n = 0; n < 8; n++) begin
			tb_cnt[n]  = 0;
			tb_bias[n] = '0;
			tb_relu[n] = 1'b0;
			exp_out[n] = '0;
		end
		load_table();
		repeat (4) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;

		// Everything reads zero out of reset
		check("rdata", rdata, '0);
		read_op(NNA_STAT, 0, got);
		check("stat", got, '0);
		for (n = 0; n < 8; n++) begin
			read_op(NNA_MFACT, n, got);
			check($sformatf("neuron_o[%0d]", n), got, '0);
		end

		for (row = 0; row < NROWS; row++) begin
			apply_row(rows[row]);
			trigger(rows[row].mask);
			read_op(NNA_STAT, 0, got);
			check("stat", got, value_t'(exp_done));
			check_outputs(rows[row].mask, rows[row].ovr_en, rows[row].ovr);
		end

		// Neuron 5 holds its bias alone, a value no other neuron shows
		read_op(NNA_MFACT, 5, got);
		check("neuron_o[5]", got, {{32{exp_out[5][31]}}, exp_out[5]});

		// Unknown codes and idle strobes must leave every neuron alone
		issue(1'b1, OP_R2, 6'h3f, 64'hff, {32'sh1234_5678, 32'h0});
		issue(1'b1, OP_R1, 6'h3e, 64'hff, '0);
		issue(1'b1, 7'h55, NNA_TRIG, 64'hff, '0);
		issue(1'b0, OP_R1, NNA_TRIG, 64'hff, '0);
		issue(1'b0, OP_R2, NNA_MTBIAS, 64'hff, {32'sh7fff_0000, 32'h0});

		// Only a read replaces the result held in rdata
		check("rdata", rdata, {{32{exp_out[5][31]}}, exp_out[5]});
		read_op(NNA_STAT, 0, got);
		check("stat", got, value_t'(exp_done));
		for (n = 0; n < 8; n++) begin
			read_op(NNA_MFACT, n, got);
			check($sformatf("neuron_o[%0d]", n), got, {{32{exp_out[n][31]}}, exp_out[n]});
		end

		// A real rerun exposes any hidden change to bias, count or memories
		trigger(8'hff);
		check_outputs(8'hff, 1'b0, '0);

		$display("*** PASSED ***");
		$finish;
	end

endmodule

// ==== sim.f ====
source/nna_pkg.sv
source/nna_mac_fx.sv
source/nna_neuron_fx.sv
source/nna_layer_fx.sv
source/nna_unit_top.sv
dv/nna_tb.sv

// ==== Bender.yml ====
package:
  name: nna

sources:
  - source/nna_pkg.sv
  - source/nna_mac_fx.sv
  - source/nna_neuron_fx.sv
  - source/nna_layer_fx.sv
  - source/nna_unit_top.sv
  - target: test
    files:
      - dv/nna_tb.sv
